// File: logic/gpuBackend_params.svh
`ifndef GPU_BACKEND_PARAMS_SVH
`define GPU_BACKEND_PARAMS_SVH

// --------------------------------------------------
// Background block geometry
// --------------------------------------------------
// Pixels held in one on-chip background block
`define BLOCK_PIXELS 16
// Two pixels per pair, so half the block size
`define PAIR_COUNT 8

// --------------------------------------------------
// Colour and coordinate widths
// --------------------------------------------------
// Channel width as delivered by the front end
`define CHAN_IN_W 8
// Channel width in the 5-5-5 frame buffer format
`define CHAN_W 5
`define SCRX_W 10
`define SCRY_W 9
// Block address is scrY joined with scrX[9:4]
`define BLOCK_ADR_W 15

`endif

// File: logic/gpuRegPkg.sv
`include "gpuBackend_params.svh"

package gpuRegPkg;

	// --------------------------------------------------
	// Semi-transparency modes
	// --------------------------------------------------
	// Encoding follows the 2-bit transparency register field
	typedef enum logic [1:0] {
		// B/2 + F/2
		AVERAGE     = 2'd0,
		// B + F, saturating
		ADD         = 2'd1,
		// B - F, floored at zero
		SUBTRACT    = 2'd2,
		// B + F/4, saturating
		ADD_QUARTER = 2'd3
	} blendMode;

	// --------------------------------------------------
	// Per-primitive setup, fixed while a primitive is drawn
	// --------------------------------------------------
	typedef struct packed {
		// Selected semi-transparency rule
		blendMode                 mode;
		// High means the front end colour is written as is
		logic                     noBlend;
		// Palette base colour, 5-5-5, not consumed by this back end
		logic [3*`CHAN_W-1:0]     clutBase;
	} primSetup;

endpackage

// File: logic/pixelPkg.sv
`include "gpuBackend_params.svh"

package pixelPkg;

	// --------------------------------------------------
	// Block operation tagged onto each pixel pair
	// --------------------------------------------------
	typedef enum logic [1:0] {
		// Stay inside the current block
		NONE  = 2'b00,
		// First block touched by a primitive
		FIRST = 2'b01,
		// Second and later blocks
		NEXT  = 2'b10
	} blockOp;

	// One lane of the pair, already shaded
	typedef struct packed {
		logic [`CHAN_IN_W-1:0] r;
		logic [`CHAN_IN_W-1:0] g;
		logic [`CHAN_IN_W-1:0] b;
		logic                  valid;
		// Sticky mask bit carried with the pixel
		logic                  bgMsk;
	} lanePixel;

	// Pair as delivered by the front end
	typedef struct packed {
		lanePixel              left;
		lanePixel              right;
		// Always even, the right lane sits at scrX + 1
		logic [`SCRX_W-1:0]    scrX;
		logic [`SCRY_W-1:0]    scrY;
		blockOp                op;
	} pixelPair;

	// Pair held in the register stage
	typedef struct packed {
		lanePixel              left;
		lanePixel              right;
		logic [`SCRX_W-1:0]    scrX;
		logic [`SCRY_W-1:0]    scrY;
		blockOp                op;
	} stagedPair;

	// --------------------------------------------------
	// Stencil cache write port
	// --------------------------------------------------
	typedef struct packed {
		logic                    write;
		logic [`BLOCK_ADR_W-1:0] adr;
		// Pair index inside the block
		logic [2:0]              pair;
		// Bit 0 left lane, bit 1 right lane
		logic [1:0]              select;
		logic [1:0]              value;
	} stencilWrite;

endpackage

// File: logic/pixelPairStage.sv
module pixelPairStage (
	input  logic                clk,
	input  logic                i_resetPixelOnNewBlock,
	input  logic                i_pausePipeline,
	input  logic                i_pairStrobe,
	input  pixelPkg::pixelPair  i_pair,
	input  logic                i_noBlend,
	output pixelPkg::stagedPair o_staged,
	output logic                o_pixelInFlight,
	output logic                o_writePixelOnNewBlock
);

	// Control part of the stage
	logic             validLReg;
	logic             validRReg;
	pixelPkg::blockOp opReg;
	// Colours and coordinates of the last accepted pair
	pixelPkg::pixelPair payloadReg;

	// --------------------------------------------------
	// Stage registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_resetPixelOnNewBlock) begin
			validLReg <= 1'b0;
			validRReg <= 1'b0;
			opReg     <= pixelPkg::NONE;
		end else if (!i_pausePipeline) begin
			// No strobe empties the stage so a pair is written only once
			validLReg <= i_pairStrobe & i_pair.left.valid;
			validRReg <= i_pairStrobe & i_pair.right.valid;
			opReg     <= i_pairStrobe ? i_pair.op : pixelPkg::NONE;
		end
	end

	always_ff @(posedge clk) begin
		// Paused strobes are dropped, upper logic never issues one
		if (!i_pausePipeline && i_pairStrobe) begin
			payloadReg <= i_pair;
		end
	end

	// Rebuild the staged pair with the live control bits
	always_comb begin
		o_staged             = payloadReg;
		o_staged.left.valid  = validLReg;
		o_staged.right.valid = validRReg;
		o_staged.op          = opReg;
	end

	assign o_pixelInFlight = validLReg | validRReg;

	// --------------------------------------------------
	// Block operation decode
	// --------------------------------------------------
	// First block needs the background only when blending
	// Later blocks always load and save
	assign o_writePixelOnNewBlock = ((opReg == pixelPkg::FIRST) & !i_noBlend)
		| (opReg == pixelPkg::NEXT);

	// Pause freezes the whole stage, control and payload alike
	holdWhilePaused: assert property (@(posedge clk) disable iff (i_resetPixelOnNewBlock)
		i_pausePipeline |=> $stable(o_staged))
		else $error("Staged pair changed while paused");

endmodule

// File: logic/pixelBlend.sv
`include "gpuBackend_params.svh"

module pixelBlend (
	input  pixelPkg::stagedPair i_staged,
	input  gpuRegPkg::primSetup i_setup,
	input  logic [31:0]         i_bgPair,
	output logic [31:0]         o_writeBack
);

	// 5-5-5 colour plus the mask bit on top
	localparam int PIX_W = 3 * `CHAN_W + 1;

	// --------------------------------------------------
	// Channel helpers
	// --------------------------------------------------
	// Keep the upper bits of the incoming channel
	function automatic logic [`CHAN_W-1:0] cutChan(input logic [`CHAN_IN_W-1:0] c);
		return c[`CHAN_IN_W-1 -: `CHAN_W];
	endfunction

	function automatic logic [`CHAN_W-1:0] blendChan(
		input logic [`CHAN_W-1:0] bg,
		input logic [`CHAN_W-1:0] fg,
		input gpuRegPkg::blendMode mode
	);
		// One extra bit catches the carry
		logic [`CHAN_W:0]   sum;
		logic [`CHAN_W-1:0] res;
		sum = '0;
		res = fg;
		case (mode)
			gpuRegPkg::AVERAGE: begin
				sum = {1'b0, bg} + {1'b0, fg};
				res = sum[`CHAN_W:1];
			end
			gpuRegPkg::ADD: begin
				sum = {1'b0, bg} + {1'b0, fg};
				res = sum[`CHAN_W] ? '1 : sum[`CHAN_W-1:0];
			end
			gpuRegPkg::SUBTRACT: begin
				// Floor at zero instead of wrapping
				res = (fg > bg) ? '0 : bg - fg;
			end
			gpuRegPkg::ADD_QUARTER: begin
				sum = {1'b0, bg} + ({1'b0, fg} >> 2);
				res = sum[`CHAN_W] ? '1 : sum[`CHAN_W-1:0];
			end
			default: begin
				res = fg;
			end
		endcase
		return res;
	endfunction

	// --------------------------------------------------
	// One lane, three channels
	// --------------------------------------------------
	function automatic logic [PIX_W-1:0] blendLane(
		input pixelPkg::lanePixel  px,
		input logic [PIX_W-1:0]    bg,
		input gpuRegPkg::primSetup setup
	);
		logic [`CHAN_W-1:0] r;
		logic [`CHAN_W-1:0] g;
		logic [`CHAN_W-1:0] b;
		r = cutChan(px.r);
		g = cutChan(px.g);
		b = cutChan(px.b);
		if (!setup.noBlend) begin
			// Background layout is R low, then G, then B
			r = blendChan(bg[`CHAN_W-1:0], r, setup.mode);
			g = blendChan(bg[2*`CHAN_W-1:`CHAN_W], g, setup.mode);
			b = blendChan(bg[3*`CHAN_W-1:2*`CHAN_W], b, setup.mode);
		end
		// Mask bit comes from the foreground pixel
		return {px.bgMsk, b, g, r};
	endfunction

	// Left lane in the low half, right lane in the high half
	always_comb begin
		o_writeBack[PIX_W-1:0]       = blendLane(i_staged.left, i_bgPair[PIX_W-1:0], i_setup);
		o_writeBack[2*PIX_W-1:PIX_W] = blendLane(i_staged.right, i_bgPair[2*PIX_W-1:PIX_W],
			i_setup);
		// Mode must be defined whenever a staged pixel is blended
		if (!i_setup.noBlend && (i_staged.left.valid || i_staged.right.valid)) begin
			knownMode: assert (i_setup.mode inside {gpuRegPkg::AVERAGE, gpuRegPkg::ADD,
				gpuRegPkg::SUBTRACT, gpuRegPkg::ADD_QUARTER})
				else $error("Unknown blend mode on a staged pixel");
		end
	end

endmodule

// File: logic/bgBlockCache.sv
`include "gpuBackend_params.svh"

module bgBlockCache (
	input  logic                         clk,
	input  logic                         i_resetPixelOnNewBlock,
	input  logic                         i_pausePipeline,
	input  pixelPkg::stagedPair          i_staged,
	input  logic [31:0]                  i_writeBack,
	input  logic                         i_importStrobe,
	input  logic [`BLOCK_PIXELS*16-1:0]  i_importedBlock,
	output logic [31:0]                  o_bgPair,
	output pixelPkg::stencilWrite        o_stencil,
	output logic [`BLOCK_ADR_W-1:0]      o_saveAdr,
	output logic [`BLOCK_PIXELS*16-1:0]  o_exportedBlock,
	output logic [`BLOCK_PIXELS-1:0]     o_exportedMask
);

	localparam int PAIR_W = $clog2(`PAIR_COUNT);

	// Block storage with one 16-bit word per pixel
	logic [`BLOCK_PIXELS-1:0][15:0] blockReg;
	logic [`BLOCK_PIXELS-1:0]       mskReg;
	logic [`BLOCK_ADR_W-1:0]        lastAdrReg;

	logic                           validL;
	logic                           validR;
	logic                           writeSig;
	logic [PAIR_W-1:0]              pairId;
	logic [PAIR_W:0]                leftIdx;
	logic [PAIR_W:0]                rightIdx;
	logic [`BLOCK_ADR_W-1:0]        writeAdr;

	assign validL   = i_staged.left.valid;
	assign validR   = i_staged.right.valid;
	// Pause blocks the write for the whole pair
	assign writeSig = !i_pausePipeline & (validL | validR);
	assign pairId   = i_staged.scrX[PAIR_W:1];
	assign leftIdx  = {pairId, 1'b0};
	assign rightIdx = {pairId, 1'b1};
	assign writeAdr = {i_staged.scrY, i_staged.scrX[`SCRX_W-1:PAIR_W+1]};

	// --------------------------------------------------
	// Background read for blending
	// --------------------------------------------------
	// Value is ignored by the blender when noBlend is high
	assign o_bgPair = {blockReg[rightIdx], blockReg[leftIdx]};

	// --------------------------------------------------
	// Write back and import
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (writeSig) begin
			lastAdrReg <= writeAdr;
			if (validL) begin
				blockReg[leftIdx] <= i_writeBack[15:0];
			end
			if (validR) begin
				blockReg[rightIdx] <= i_writeBack[31:16];
			end
		end else if (i_importStrobe) begin
			// Whole block arrives in one cycle from the memory side
			blockReg <= i_importedBlock;
		end
	end

	// Mask marks pixels written since the block was opened
	always_ff @(posedge clk) begin
		if (i_resetPixelOnNewBlock) begin
			mskReg <= '0;
		end else if (writeSig) begin
			if (validL) begin
				mskReg[leftIdx] <= 1'b1;
			end
			if (validR) begin
				mskReg[rightIdx] <= 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// Stencil port and export
	// --------------------------------------------------
	assign o_stencil.write  = writeSig;
	assign o_stencil.adr    = writeAdr;
	assign o_stencil.pair   = pairId;
	assign o_stencil.select = {validR, validL};
	// Sticky bit only survives on active pixels
	assign o_stencil.value  = {i_staged.right.bgMsk & validR, i_staged.left.bgMsk & validL};

	assign o_saveAdr       = lastAdrReg;
	assign o_exportedBlock = blockReg;
	assign o_exportedMask  = mskReg;

	stencilSelect: assert property (@(posedge clk) disable iff (i_resetPixelOnNewBlock)
		o_stencil.write |-> (o_stencil.select != 2'b00))
		else $error("Stencil write with no lane selected");

endmodule

// File: logic/gpuBackend.sv
`include "gpuBackend_params.svh"

module gpuBackend (
	input  logic                         clk,
	input  logic                         i_resetPixelOnNewBlock,
	input  logic                         i_pausePipeline,
	input  logic                         i_pairStrobe,
	input  pixelPkg::pixelPair           i_pair,
	input  gpuRegPkg::primSetup          i_setup,
	input  logic                         i_flushLastBlock,
	input  logic                         i_importStrobe,
	input  logic [`BLOCK_PIXELS*16-1:0]  i_importedBlock,
	output logic                         o_pixelInFlight,
	output logic                         o_writePixelOnNewBlock,
	output pixelPkg::blockOp             o_saveBGBlock,
	output logic [`BLOCK_ADR_W-1:0]      o_loadAdr,
	output logic [`BLOCK_ADR_W-1:0]      o_saveAdr,
	output pixelPkg::stencilWrite        o_stencil,
	output logic [`BLOCK_PIXELS*16-1:0]  o_exportedBlock,
	output logic [`BLOCK_PIXELS-1:0]     o_exportedMask
);

	// Pair currently in flight
	pixelPkg::stagedPair staged;
	// Background pair under the staged pixels
	logic [31:0]         bgPair;
	// Blended result for both lanes
	logic [31:0]         writeBack;

	pixelPairStage pixelPairStage_i (
		.clk                    (clk),
		.i_resetPixelOnNewBlock (i_resetPixelOnNewBlock),
		.i_pausePipeline        (i_pausePipeline),
		.i_pairStrobe           (i_pairStrobe),
		.i_pair                 (i_pair),
		.i_noBlend              (i_setup.noBlend),
		.o_staged               (staged),
		.o_pixelInFlight        (o_pixelInFlight),
		.o_writePixelOnNewBlock (o_writePixelOnNewBlock)
	);

	// Palette base in the setup has no consumer past this point
	pixelBlend pixelBlend_i (
		.i_staged    (staged),
		.i_setup     (i_setup),
		.i_bgPair    (bgPair),
		.o_writeBack (writeBack)
	);

	bgBlockCache bgBlockCache_i (
		.clk                    (clk),
		.i_resetPixelOnNewBlock (i_resetPixelOnNewBlock),
		.i_pausePipeline        (i_pausePipeline),
		.i_staged               (staged),
		.i_writeBack            (writeBack),
		.i_importStrobe         (i_importStrobe),
		.i_importedBlock        (i_importedBlock),
		.o_bgPair               (bgPair),
		.o_stencil              (o_stencil),
		.o_saveAdr              (o_saveAdr),
		.o_exportedBlock        (o_exportedBlock),
		.o_exportedMask         (o_exportedMask)
	);

	// --------------------------------------------------
	// Memory side requests
	// --------------------------------------------------
	assign o_loadAdr     = {staged.scrY, staged.scrX[`SCRX_W-1:4]};
	// Flush pushes out the last open block as a save
	assign o_saveBGBlock = i_flushLastBlock ? pixelPkg::NEXT : staged.op;

endmodule

// File: dv/gpuBackendTb.sv
`include "gpuBackend_params.svh"

module gpuBackendTb;

	localparam int PERIOD       = 100;
	localparam int RESET_CYCLES = 8;
	localparam int BLK_W        = `BLOCK_PIXELS * 16;

	// One row of the stimulus table
	typedef struct {
		string               name;
		gpuRegPkg::primSetup setup;
		pixelPkg::pixelPair  pair;
		logic                pause;
		logic                doImport;
		logic [BLK_W-1:0]    importBlk;
		logic                flush;
		// Block requests expected while the pair is staged
		logic                expNewBlock;
		pixelPkg::blockOp    expSaveOp;
	} tableEntry;

	logic                        clk;
	logic                        resetPixelOnNewBlock;
	logic                        pausePipeline;
	logic                        pairStrobe;
	pixelPkg::pixelPair          pair;
	gpuRegPkg::primSetup         setup;
	logic                        flushLastBlock;
	logic                        importStrobe;
	logic [BLK_W-1:0]            importedBlock;
	logic                        pixelInFlight;
	logic                        writePixelOnNewBlock;
	pixelPkg::blockOp            saveBGBlock;
	logic [`BLOCK_ADR_W-1:0]     loadAdr;
	logic [`BLOCK_ADR_W-1:0]     saveAdr;
	pixelPkg::stencilWrite       stencil;
	logic [BLK_W-1:0]            exportedBlock;
	logic [`BLOCK_PIXELS-1:0]    exportedMask;

	// Mirror of the background block and its mask
	logic [`BLOCK_PIXELS-1:0][15:0] modelBlk;
	logic [`BLOCK_PIXELS-1:0]       modelMsk;
	tableEntry                      tableQ[$];
	logic                           tableBuilt;
	int                             checkCount;
	int                             errorCount;

	gpuBackend gpuBackend_i (
		.clk                    (clk),
		.i_resetPixelOnNewBlock (resetPixelOnNewBlock),
		.i_pausePipeline        (pausePipeline),
		.i_pairStrobe           (pairStrobe),
		.i_pair                 (pair),
		.i_setup                (setup),
		.i_flushLastBlock       (flushLastBlock),
		.i_importStrobe         (importStrobe),
		.i_importedBlock        (importedBlock),
		.o_pixelInFlight        (pixelInFlight),
		.o_writePixelOnNewBlock (writePixelOnNewBlock),
		.o_saveBGBlock          (saveBGBlock),
		.o_loadAdr              (loadAdr),
		.o_saveAdr              (saveAdr),
		.o_stencil              (stencil),
		.o_exportedBlock        (exportedBlock),
		.o_exportedMask         (exportedMask)
	);

	always #(PERIOD / 2) clk = ~clk;

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	// Semi-transparency rule on one 5-bit channel
	function automatic int blendChannel(input int bg, input int fg,
		input gpuRegPkg::blendMode mode);
		int res;
		case (mode)
			gpuRegPkg::AVERAGE:  res = (bg + fg) / 2;
			gpuRegPkg::ADD:      res = (bg + fg > 31) ? 31 : bg + fg;
			gpuRegPkg::SUBTRACT: res = (fg > bg) ? 0 : bg - fg;
			default:             res = (bg + fg / 4 > 31) ? 31 : bg + fg / 4;
		endcase
		return res;
	endfunction

	// Word layout is R in the low bits, then G, B and the mask bit on top
	function automatic logic [15:0] expectedPixel(input pixelPkg::lanePixel px,
		input logic [15:0] bg, input gpuRegPkg::primSetup s);
		int ch[3];
		ch[0] = int'(px.r) / 8;
		ch[1] = int'(px.g) / 8;
		ch[2] = int'(px.b) / 8;
		for (int i = 0; i < 3; i++) begin
			if (!s.noBlend) begin
				ch[i] = blendChannel(int'(bg[5*i +: 5]), ch[i], s.mode);
			end
		end
		return {px.bgMsk, ch[2][4:0], ch[1][4:0], ch[0][4:0]};
	endfunction

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	function automatic pixelPkg::lanePixel randomLane(input logic valid);
		pixelPkg::lanePixel px;
		px.r     = 8'($urandom);
		px.g     = 8'($urandom);
		px.b     = 8'($urandom);
		px.valid = valid;
		px.bgMsk = 1'($urandom);
		return px;
	endfunction

	function automatic pixelPkg::lanePixel solidLane(input pixelPkg::lanePixel px,
		input logic [7:0] c);
		px.r = c;
		px.g = c;
		px.b = c;
		return px;
	endfunction

	// Pair at block column blkX, pair slot p, line y
	function automatic pixelPkg::pixelPair makePair(input logic [5:0] blkX, input logic [2:0] p,
		input logic [8:0] y, input logic vL, input logic vR, input pixelPkg::blockOp op);
		pixelPkg::pixelPair pr;
		pr.left  = randomLane(vL);
		pr.right = randomLane(vR);
		pr.scrX  = {blkX, p, 1'b0};
		pr.scrY  = y;
		pr.op    = op;
		return pr;
	endfunction

	function automatic logic [BLK_W-1:0] randomBlock();
		logic [BLK_W-1:0] blk;
		for (int i = 0; i < BLK_W / 32; i++) begin
			blk[32*i +: 32] = $urandom;
		end
		return blk;
	endfunction

	// Same colour everywhere with random mask bits
	function automatic logic [BLK_W-1:0] solidBlock(input logic [14:0] colour);
		logic [BLK_W-1:0] blk;
		for (int i = 0; i < `BLOCK_PIXELS; i++) begin
			blk[16*i +: 16] = {1'($urandom), colour};
		end
		return blk;
	endfunction

	function automatic gpuRegPkg::primSetup setupOf(input gpuRegPkg::blendMode mode,
		input logic nb);
		gpuRegPkg::primSetup s;
		s.mode     = mode;
		s.noBlend  = nb;
		s.clutBase = 15'($urandom);
		return s;
	endfunction

	function automatic void addEntry(input string name, input gpuRegPkg::primSetup s,
		input pixelPkg::pixelPair pr, input logic pause, input logic doImport,
		input logic [BLK_W-1:0] blk, input logic flush, input logic expNb,
		input pixelPkg::blockOp expSave);
		tableEntry e;
		e.name        = name;
		e.setup       = s;
		e.pair        = pr;
		e.pause       = pause;
		e.doImport    = doImport;
		e.importBlk   = blk;
		e.flush       = flush;
		e.expNewBlock = expNb;
		e.expSaveOp   = expSave;
		tableQ.push_back(e);
	endfunction

	// --------------------------------------------------
	// Stimulus table
	// --------------------------------------------------
	task automatic buildTable();
		pixelPkg::pixelPair  pr;
		pixelPkg::blockOp    op;
		gpuRegPkg::blendMode mode;
		logic [14:0]         bgColour;
		// Straight writes at every slot with slot 2 left only and slot 5 right only
		for (int p = 0; p < `PAIR_COUNT; p++) begin
			op = (p == 0) ? pixelPkg::FIRST : (p == 6) ? pixelPkg::NEXT : pixelPkg::NONE;
			pr = makePair(6'd5, 3'(p), 9'd40, p != 5, p != 2, op);
			addEntry($sformatf("noBlend pair %0d", p), setupOf(gpuRegPkg::AVERAGE, 1'b1), pr,
				1'b0, p == 0, randomBlock(), p == 3, p == 6,
				(p == 3 || p == 6) ? pixelPkg::NEXT : op);
		end
		for (int m = 0; m < 4; m++) begin
			mode = gpuRegPkg::blendMode'(m);
			op   = (m == 0) ? pixelPkg::FIRST : pixelPkg::NONE;
			pr   = makePair(6'(m + 9), 3'($urandom), 9'($urandom), 1'b1, 1'b1, op);
			addEntry($sformatf("%s random", mode.name()), setupOf(mode, 1'b0), pr, 1'b0, 1'b1,
				randomBlock(), 1'b0, m == 0, op);
			// Full-scale foreground over a full or empty background hits the clamps
			pr       = makePair(6'(m + 9), 3'(m * 2 + 1), 9'd300, 1'b1, 1'b1, pixelPkg::NONE);
			pr.left  = solidLane(pr.left, 8'hFF);
			pr.right = solidLane(pr.right, 8'hFF);
			bgColour = (mode == gpuRegPkg::SUBTRACT) ? 15'h0000 : 15'h7FFF;
			addEntry($sformatf("%s clamp", mode.name()), setupOf(mode, 1'b0), pr, m % 2 == 1,
				1'b1, solidBlock(bgColour), 1'b0, 1'b0, pixelPkg::NONE);
		end
	endtask

	task automatic checkValue(input string testName, input string what,
		input logic [BLK_W-1:0] expected, input logic [BLK_W-1:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("FAIL %s %s: expected %0h actual %0h", testName, what, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// One table row, starting and ending on a falling edge
	// --------------------------------------------------
	task automatic applyEntry(input tableEntry e);
		pixelPkg::stencilWrite expSt;
		logic [31:0]           expWb;
		int                    lIdx;
		int                    rIdx;
		lIdx = 2 * int'(e.pair.scrX[3:1]);
		rIdx = lIdx + 1;
		if (e.doImport) begin
			importStrobe  = 1'b1;
			importedBlock = e.importBlk;
			@(negedge clk);
			importStrobe = 1'b0;
			modelBlk     = e.importBlk;
		end
		setup          = e.setup;
		pair           = e.pair;
		flushLastBlock = e.flush;
		pairStrobe     = 1'b1;
		@(negedge clk);
		pairStrobe = 1'b0;
		// Pair now sits in the stage
		expSt.write  = 1'b1;
		expSt.adr    = {e.pair.scrY, e.pair.scrX[`SCRX_W-1:4]};
		expSt.pair   = e.pair.scrX[3:1];
		expSt.select = {e.pair.right.valid, e.pair.left.valid};
		expSt.value  = {e.pair.right.valid & e.pair.right.bgMsk,
			e.pair.left.valid & e.pair.left.bgMsk};
		checkValue(e.name, "stencil", expSt, stencil);
		checkValue(e.name, "load address", expSt.adr, loadAdr);
		checkValue(e.name, "pixel in flight", 1'b1, pixelInFlight);
		checkValue(e.name, "new block flag", e.expNewBlock, writePixelOnNewBlock);
		checkValue(e.name, "save block op", e.expSaveOp, saveBGBlock);
		flushLastBlock = 1'b0;
		expWb = {expectedPixel(e.pair.right, modelBlk[rIdx], e.setup),
			expectedPixel(e.pair.left, modelBlk[lIdx], e.setup)};
		if (e.pause) begin
			// Strobe is lost and the staged pair stays put
			pausePipeline = 1'b1;
			pairStrobe    = 1'b1;
			pair          = makePair(6'h3F, 3'd7, 9'h1FF, 1'b1, 1'b1, pixelPkg::NEXT);
			@(negedge clk);
			// Only the write strobe drops while paused
			expSt.write = 1'b0;
			checkValue(e.name, "paused stencil", expSt, stencil);
			checkValue(e.name, "paused block", modelBlk, exportedBlock);
			checkValue(e.name, "paused mask", modelMsk, exportedMask);
			pausePipeline = 1'b0;
			pairStrobe    = 1'b0;
		end
		@(negedge clk);
		// Write-back landed on the last edge
		if (e.pair.left.valid) begin
			modelBlk[lIdx] = expWb[15:0];
			modelMsk[lIdx] = 1'b1;
		end
		if (e.pair.right.valid) begin
			modelBlk[rIdx] = expWb[31:16];
			modelMsk[rIdx] = 1'b1;
		end
		checkValue(e.name, "exported block", modelBlk, exportedBlock);
		checkValue(e.name, "exported mask", modelMsk, exportedMask);
		checkValue(e.name, "save address", expSt.adr, saveAdr);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(35126));
		clk                  = 1'b0;
		resetPixelOnNewBlock = 1'b1;
		pausePipeline        = 1'b0;
		pairStrobe           = 1'b0;
		pair                 = '0;
		setup                = '0;
		flushLastBlock       = 1'b0;
		importStrobe         = 1'b0;
		importedBlock        = '0;
		checkCount           = 0;
		errorCount           = 0;
		modelMsk             = '0;
		tableBuilt           = 1'b0;
		buildTable();
		tableBuilt = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		resetPixelOnNewBlock = 1'b0;
		checkValue("reset", "exported mask", '0, exportedMask);
		checkValue("reset", "new block flag", 1'b0, writePixelOnNewBlock);
		checkValue("reset", "pixel in flight", 1'b0, pixelInFlight);
		checkValue("reset", "stencil write", 1'b0, stencil.write);
		foreach (tableQ[i]) begin
			applyEntry(tableQ[i]);
		end
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Each row needs at most four cycles
	initial begin
		wait (tableBuilt);
		#((tableQ.size() * 4 + RESET_CYCLES + 2) * PERIOD);
		$display("Watchdog expired before all table rows were applied");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: tb.f
+incdir+logic
logic/gpuRegPkg.sv
logic/pixelPkg.sv
logic/pixelPairStage.sv
logic/pixelBlend.sv
logic/bgBlockCache.sv
logic/gpuBackend.sv
dv/gpuBackendTb.sv

// File: Makefile
SIM  := obj_dir/VgpuBackendTb
SRCS := $(shell grep -v '^+' tb.f) logic/gpuBackend_params.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module gpuBackendTb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
